/* hdl/mcoi_pkg.sv */
`default_nettype none

package mcoi_pkg;

   // ------------------------------------------------------------
   // widths that carry a meaning
   // ------------------------------------------------------------

   // one slow-control word, as carried by a lane
   typedef logic [31:0] sc_word_t;

   // index into the four-page configuration memory
   typedef logic [1:0] page_t;

   // fibre frame, 4 bits per motor
   // received: clk, en, dir, boost from bit 4m upwards
   // sent: pfail, sw_a, sw_b, overheat from bit 4m upwards
   typedef logic [63:0] motor_frame_t;

   // one bit per motor
   typedef logic [15:0] motor_pins_t;

   // ------------------------------------------------------------
   // page map
   // ------------------------------------------------------------

   // loopback flag in bit 31, build number below
   localparam page_t PAGE_BUILD = 2'd0;
   // last word received on lane 1
   localparam page_t PAGE_LOOP  = 2'd1;
   // number of lane 1 updates
   localparam page_t PAGE_COUNT = 2'd2;
   // motor enable in bit 0
   localparam page_t PAGE_STATE = 2'd3;

   // start bit, 32 data bits, stop bit
   localparam int SC_FRAME_BITS = 34;

endpackage

`default_nettype wire

/* hdl/wb_if.sv */
`timescale 1ns/1ps
`default_nettype none

// wishbone classic, single word, no byte selects
interface wb_if;

   logic               cyc;
   logic               stb;
   logic               we;
   mcoi_pkg::page_t    adr;
   mcoi_pkg::sc_word_t dat_w;
   mcoi_pkg::sc_word_t dat_r;
   // one-cycle pulse from the slave
   logic               ack;

   modport master (
      output cyc, stb, we, adr, dat_w,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w,
      output dat_r, ack
   );

endinterface

`default_nettype wire

/* hdl/serial_register.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_register (
   input  logic               gbt_data_x,
   input  logic               rst_n_i,
   input  logic               rx_i,
   output logic               tx_o,
   output mcoi_pkg::sc_word_t rx_word_o,
   output logic               rx_valid_o,
   input  mcoi_pkg::sc_word_t tx_word_i,
   input  logic               tx_load_i
);

   localparam int FRAME_BITS = mcoi_pkg::SC_FRAME_BITS;
   localparam int WORD_BITS  = $bits(mcoi_pkg::sc_word_t);
   localparam int CNT_W      = $clog2(FRAME_BITS);

   typedef enum logic [1:0] {RX_IDLE, RX_DATA, RX_STOP} rx_state_t;
   typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;

   rx_state_t             rx_state;
   logic [CNT_W-1:0]      rx_cnt;
   mcoi_pkg::sc_word_t    rx_sh;

   tx_state_t             tx_state;
   logic [CNT_W-1:0]      tx_cnt;
   logic [FRAME_BITS-1:0] tx_sh;
   mcoi_pkg::sc_word_t    buf_word;
   logic                  buf_full;
   logic                  buf_take;

   // ------------------------------------------------------------
   // receiver
   // ------------------------------------------------------------

   // line idles high, a low bit in idle is the start bit
   always_ff @(posedge gbt_data_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rx_state   <= RX_IDLE;
         rx_cnt     <= '0;
         rx_valid_o <= 1'b0;
      end else begin
         rx_valid_o <= 1'b0;
         case (rx_state)
            RX_IDLE: begin
               rx_cnt <= '0;
               if (!rx_i)
                  rx_state <= RX_DATA;
            end
            RX_DATA: begin
               rx_cnt <= rx_cnt + 1'b1;
               if (rx_cnt == CNT_W'(WORD_BITS - 1))
                  rx_state <= RX_STOP;
            end
            default: begin
               // a low stop bit is a framing error, word is dropped
               rx_valid_o <= rx_i;
               rx_state   <= RX_IDLE;
            end
         endcase
      end
   end

   // msb arrives first
   always_ff @(posedge gbt_data_x) begin
      if (rx_state == RX_DATA)
         rx_sh <= {rx_sh[WORD_BITS-2:0], rx_i};
   end

   // shifter is frozen until the next start bit, so valid with the strobe
   assign rx_word_o = rx_sh;

   // ------------------------------------------------------------
   // transmitter
   // ------------------------------------------------------------

   // buffer moves into the shifter whenever the shifter is free
   assign buf_take = (tx_state == TX_IDLE) && buf_full;

   always_ff @(posedge gbt_data_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tx_state <= TX_IDLE;
         tx_cnt   <= '0;
         tx_o     <= 1'b1;
         buf_full <= 1'b0;
      end else begin
         // a load into a full buffer that is not emptying is lost
         buf_full <= tx_load_i || (buf_full && !buf_take);
         case (tx_state)
            TX_IDLE: begin
               tx_o   <= 1'b1;
               tx_cnt <= '0;
               if (buf_full)
                  tx_state <= TX_SHIFT;
            end
            default: begin
               tx_o   <= tx_sh[FRAME_BITS-1];
               tx_cnt <= tx_cnt + 1'b1;
               if (tx_cnt == CNT_W'(FRAME_BITS - 1))
                  tx_state <= TX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge gbt_data_x) begin
      if (tx_load_i && (!buf_full || buf_take))
         buf_word <= tx_word_i;
      // start bit first, stop bit last, line refills with ones
      if (buf_take)
         tx_sh <= {1'b0, buf_word, 1'b1};
      else if (tx_state == TX_SHIFT)
         tx_sh <= {tx_sh[FRAME_BITS-2:0], 1'b1};
   end

endmodule

`default_nettype wire

/* hdl/page_selector.sv */
`timescale 1ns/1ps
`default_nettype none

// lane 0: flag write, page read, reply
module page_selector (
   input  logic               gbt_data_x,
   input  logic               rst_n_i,
   input  mcoi_pkg::sc_word_t rx_word_i,
   input  logic               rx_valid_i,
   output mcoi_pkg::sc_word_t tx_word_o,
   output logic               tx_load_o,
   wb_if.master               wb
);

   typedef enum logic [1:0] {IDLE, WR_FLAG, RD_PAGE, REPLY} state_t;

   state_t             state;
   mcoi_pkg::sc_word_t req_word;

   always_ff @(posedge gbt_data_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:
               if (rx_valid_i)
                  state <= WR_FLAG;
            WR_FLAG:
               if (wb.ack)
                  state <= RD_PAGE;
            RD_PAGE:
               if (wb.ack)
                  state <= REPLY;
            default:
               state <= IDLE;
         endcase
      end
   end

   // request word and the page read back
   always_ff @(posedge gbt_data_x) begin
      if ((state == IDLE) && rx_valid_i)
         req_word <= rx_word_i;
      if ((state == RD_PAGE) && wb.ack)
         tx_word_o <= wb.dat_r;
   end

   // cyc stays high across both transfers, so the grant is kept
   assign wb.cyc   = (state == WR_FLAG) || (state == RD_PAGE);
   assign wb.stb   = wb.cyc;
   assign wb.we    = (state == WR_FLAG);
   // page 0 takes the flag from bit 31, low two bits pick the page
   assign wb.adr   = (state == WR_FLAG) ? mcoi_pkg::PAGE_BUILD : req_word[1:0];
   assign wb.dat_w = req_word;

   assign tx_load_o = (state == REPLY);

endmodule

`default_nettype wire

/* hdl/loopback_register.sv */
`timescale 1ns/1ps
`default_nettype none

// lane 1: echo every word and store it in page 1
module loopback_register (
   input  logic               gbt_data_x,
   input  logic               rst_n_i,
   input  mcoi_pkg::sc_word_t rx_word_i,
   input  logic               rx_valid_i,
   output mcoi_pkg::sc_word_t tx_word_o,
   output logic               tx_load_o,
   wb_if.master               wb
);

   mcoi_pkg::sc_word_t data_q;
   logic               pend;

   always_ff @(posedge gbt_data_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pend      <= 1'b0;
         tx_load_o <= 1'b0;
      end else begin
         // echo goes out the cycle after the word
         tx_load_o <= rx_valid_i;
         // a new word keeps the write pending with fresh data
         if (rx_valid_i)
            pend <= 1'b1;
         else if (wb.ack)
            pend <= 1'b0;
      end
   end

   // latest word, used for the echo and the page write alike
   always_ff @(posedge gbt_data_x) begin
      if (rx_valid_i)
         data_q <= rx_word_i;
   end

   assign tx_word_o = data_q;

   // write only, read data is never looked at
   assign wb.cyc   = pend;
   assign wb.stb   = pend;
   assign wb.we    = 1'b1;
   assign wb.adr   = mcoi_pkg::PAGE_LOOP;
   assign wb.dat_w = data_q;

endmodule

`default_nettype wire

/* hdl/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// two masters onto one slave, round robin
module wb_arbiter (
   input logic  gbt_data_x,
   input logic  rst_n_i,
   wb_if.slave  m0,
   wb_if.slave  m1,
   wb_if.master s
);

   // bus owned by gnt while locked
   logic locked;
   logic gnt;
   // master that wins a tie
   logic prio;
   logic pick;
   logic gnt_cyc;

   assign pick    = (m0.cyc && m1.cyc) ? prio : m1.cyc;
   assign gnt_cyc = gnt ? m1.cyc : m0.cyc;

   always_ff @(posedge gbt_data_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         locked <= 1'b0;
         gnt    <= 1'b0;
         prio   <= 1'b0;
      end else begin
         if (!locked) begin
            if (m0.cyc || m1.cyc) begin
               locked <= 1'b1;
               gnt    <= pick;
            end
         end else if (!gnt_cyc) begin
            // owner dropped cyc, bus is free again
            locked <= 1'b0;
         end
         // other master goes first after each completed transfer
         if (s.ack)
            prio <= ~gnt;
      end
   end

   // ------------------------------------------------------------
   // request path
   // ------------------------------------------------------------

   assign s.cyc   = locked && gnt_cyc;
   assign s.stb   = locked && (gnt ? m1.stb : m0.stb);
   assign s.we    = gnt ? m1.we    : m0.we;
   assign s.adr   = gnt ? m1.adr   : m0.adr;
   assign s.dat_w = gnt ? m1.dat_w : m0.dat_w;

   // ------------------------------------------------------------
   // response path, granted master only
   // ------------------------------------------------------------

   assign m0.ack   = s.ack && locked && !gnt;
   assign m1.ack   = s.ack && locked && gnt;
   assign m0.dat_r = (locked && !gnt) ? s.dat_r : '0;
   assign m1.dat_r = (locked && gnt) ? s.dat_r : '0;

endmodule

`default_nettype wire

/* hdl/config_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module config_memory #(
   parameter logic [30:0]        BUILD_NUMBER  = 31'd1,
   parameter mcoi_pkg::sc_word_t INTERLOCK_KEY = 32'h6e0f_1c3a
) (
   input  logic gbt_data_x,
   input  logic rst_n_i,
   wb_if.slave  wb,
   output logic motor_enable_o,
   output logic frame_loop_o
);

   logic               flag_q;
   mcoi_pkg::sc_word_t loop_word_q;
   mcoi_pkg::sc_word_t wr_count_q;
   logic               access;

   // new transfer, the ack cycle itself is not a second one
   assign access = wb.cyc && wb.stb && !wb.ack;

   always_ff @(posedge gbt_data_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         flag_q      <= 1'b0;
         loop_word_q <= '0;
         wr_count_q  <= '0;
         wb.ack      <= 1'b0;
      end else begin
         wb.ack <= access;
         if (access && wb.we) begin
            case (wb.adr)
               mcoi_pkg::PAGE_BUILD:
                  flag_q <= wb.dat_w[31];
               mcoi_pkg::PAGE_LOOP: begin
                  loop_word_q <= wb.dat_w;
                  wr_count_q  <= wr_count_q + 1'b1;
               end
               // count and state pages are read only
               default: ;
            endcase
         end
      end
   end

   // read mux, held stable by the master until ack
   always_comb begin
      case (wb.adr)
         mcoi_pkg::PAGE_BUILD: wb.dat_r = {flag_q, BUILD_NUMBER};
         mcoi_pkg::PAGE_LOOP:  wb.dat_r = loop_word_q;
         mcoi_pkg::PAGE_COUNT: wb.dat_r = wr_count_q;
         default:              wb.dat_r = {31'd0, motor_enable_o};
      endcase
   end

   // interlock closed only while lane 1 holds the key
   assign motor_enable_o = (loop_word_q == INTERLOCK_KEY);
   assign frame_loop_o   = flag_q;

endmodule

`default_nettype wire

/* hdl/motor_frame_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_frame_mux (
   input  logic                   gbt_data_x,
   input  logic                   rst_n_i,
   input  mcoi_pkg::motor_frame_t frame_rx_i,
   output mcoi_pkg::motor_frame_t frame_tx_o,
   input  logic                   motor_enable_i,
   input  logic                   frame_loop_i,
   input  mcoi_pkg::motor_pins_t  pfail_i,
   input  mcoi_pkg::motor_pins_t  sw_a_i,
   input  mcoi_pkg::motor_pins_t  sw_b_i,
   output mcoi_pkg::motor_pins_t  boost_o,
   output mcoi_pkg::motor_pins_t  dir_o,
   output mcoi_pkg::motor_pins_t  en_o,
   output mcoi_pkg::motor_pins_t  clk_o
);

   localparam int MOTORS = $bits(mcoi_pkg::motor_pins_t);

   // every output one register behind its inputs
   always_ff @(posedge gbt_data_x or negedge rst_n_i) begin
      if (!rst_n_i) begin
         frame_tx_o <= '0;
         boost_o    <= '0;
         dir_o      <= '0;
         en_o       <= '0;
         clk_o      <= '0;
      end else begin
         for (int m = 0; m < MOTORS; m++) begin
            // received nibble is clk, en, dir, boost from the lsb
            clk_o[m]   <= motor_enable_i && frame_rx_i[4*m];
            en_o[m]    <= motor_enable_i && frame_rx_i[4*m+1];
            dir_o[m]   <= motor_enable_i && frame_rx_i[4*m+2];
            boost_o[m] <= motor_enable_i && frame_rx_i[4*m+3];
            // sent nibble is pfail, sw_a, sw_b, overheat (not sensed)
            if (frame_loop_i)
               frame_tx_o[4*m +: 4] <= frame_rx_i[4*m +: 4];
            else
               frame_tx_o[4*m +: 4] <= {1'b0, sw_b_i[m], sw_a_i[m], pfail_i[m]};
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/mcoi_frame_system.sv */
`timescale 1ns/1ps
`default_nettype none

module mcoi_frame_system #(
   parameter logic [30:0]        BUILD_NUMBER  = 31'd1,
   parameter mcoi_pkg::sc_word_t INTERLOCK_KEY = 32'h6e0f_1c3a
) (
   input  logic                   gbt_data_x,
   input  logic                   rst_n_i,
   input  mcoi_pkg::motor_frame_t frame_rx_i,
   output mcoi_pkg::motor_frame_t frame_tx_o,
   input  logic [1:0]             sc_rx_i,
   output logic [1:0]             sc_tx_o,
   input  mcoi_pkg::motor_pins_t  motor_pfail_i,
   input  mcoi_pkg::motor_pins_t  motor_sw_a_i,
   input  mcoi_pkg::motor_pins_t  motor_sw_b_i,
   output mcoi_pkg::motor_pins_t  motor_boost_o,
   output mcoi_pkg::motor_pins_t  motor_dir_o,
   output mcoi_pkg::motor_pins_t  motor_en_o,
   output mcoi_pkg::motor_pins_t  motor_clk_o
);

   // per lane, index 0 is the page selector, 1 the loopback
   mcoi_pkg::sc_word_t rx_word [2];
   logic               rx_valid [2];
   mcoi_pkg::sc_word_t tx_word [2];
   logic               tx_load [2];

   logic motor_enable;
   logic frame_loop;

   wb_if wb_m0 ();
   wb_if wb_m1 ();
   wb_if wb_s ();

   // ------------------------------------------------------------
   // slow-control lanes
   // ------------------------------------------------------------

   serial_register i_serial_register_0 (
      .gbt_data_x (gbt_data_x),
      .rst_n_i    (rst_n_i),
      .rx_i       (sc_rx_i[0]),
      .tx_o       (sc_tx_o[0]),
      .rx_word_o  (rx_word[0]),
      .rx_valid_o (rx_valid[0]),
      .tx_word_i  (tx_word[0]),
      .tx_load_i  (tx_load[0])
   );

   serial_register i_serial_register_1 (
      .gbt_data_x (gbt_data_x),
      .rst_n_i    (rst_n_i),
      .rx_i       (sc_rx_i[1]),
      .tx_o       (sc_tx_o[1]),
      .rx_word_o  (rx_word[1]),
      .rx_valid_o (rx_valid[1]),
      .tx_word_i  (tx_word[1]),
      .tx_load_i  (tx_load[1])
   );

   page_selector i_page_selector (
      .gbt_data_x (gbt_data_x),
      .rst_n_i    (rst_n_i),
      .rx_word_i  (rx_word[0]),
      .rx_valid_i (rx_valid[0]),
      .tx_word_o  (tx_word[0]),
      .tx_load_o  (tx_load[0]),
      .wb         (wb_m0)
   );

   loopback_register i_loopback_register (
      .gbt_data_x (gbt_data_x),
      .rst_n_i    (rst_n_i),
      .rx_word_i  (rx_word[1]),
      .rx_valid_i (rx_valid[1]),
      .tx_word_o  (tx_word[1]),
      .tx_load_o  (tx_load[1]),
      .wb         (wb_m1)
   );

   // ------------------------------------------------------------
   // shared configuration memory
   // ------------------------------------------------------------

   wb_arbiter i_wb_arbiter (
      .gbt_data_x (gbt_data_x),
      .rst_n_i    (rst_n_i),
      .m0         (wb_m0),
      .m1         (wb_m1),
      .s          (wb_s)
   );

   config_memory #(
      .BUILD_NUMBER  (BUILD_NUMBER),
      .INTERLOCK_KEY (INTERLOCK_KEY)
   ) i_config_memory (
      .gbt_data_x     (gbt_data_x),
      .rst_n_i        (rst_n_i),
      .wb             (wb_s),
      .motor_enable_o (motor_enable),
      .frame_loop_o   (frame_loop)
   );

   // frame to motor pins and status back to frame
   motor_frame_mux i_motor_frame_mux (
      .gbt_data_x     (gbt_data_x),
      .rst_n_i        (rst_n_i),
      .frame_rx_i     (frame_rx_i),
      .frame_tx_o     (frame_tx_o),
      .motor_enable_i (motor_enable),
      .frame_loop_i   (frame_loop),
      .pfail_i        (motor_pfail_i),
      .sw_a_i         (motor_sw_a_i),
      .sw_b_i         (motor_sw_b_i),
      .boost_o        (motor_boost_o),
      .dir_o          (motor_dir_o),
      .en_o           (motor_en_o),
      .clk_o          (motor_clk_o)
   );

endmodule

`default_nettype wire

/* tb/mcoi_frame_system_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// frame and pin rules bound into mcoi_frame_system
module mcoi_frame_system_properties (
   input logic                   gbt_data_x,
   input logic                   rst_n_i,
   input mcoi_pkg::motor_frame_t frame_rx_i,
   input mcoi_pkg::motor_frame_t frame_tx_i,
   input mcoi_pkg::motor_pins_t  pfail_i,
   input mcoi_pkg::motor_pins_t  sw_a_i,
   input mcoi_pkg::motor_pins_t  sw_b_i,
   input mcoi_pkg::motor_pins_t  boost_i,
   input mcoi_pkg::motor_pins_t  dir_i,
   input mcoi_pkg::motor_pins_t  en_i,
   input mcoi_pkg::motor_pins_t  clk_i,
   input logic                   motor_enable_i,
   input logic                   frame_loop_i
);

   // number of failed assertions so far
   int fail_count = 0;

   // bit k of each received nibble for all 16 motors
   function automatic mcoi_pkg::motor_pins_t lane_bits(input mcoi_pkg::motor_frame_t f,
                                                       input int k);
      mcoi_pkg::motor_pins_t p;
      for (int m = 0; m < 16; m++)
         p[m] = f[4*m + k];
      return p;
   endfunction

   // expected sent frame with pfail, sw_a and sw_b from the lsb of each nibble
   // and the overheat bit held at zero
   function automatic mcoi_pkg::motor_frame_t status_frame(input mcoi_pkg::motor_pins_t pf,
                                                           input mcoi_pkg::motor_pins_t sa,
                                                           input mcoi_pkg::motor_pins_t sb);
      mcoi_pkg::motor_frame_t f;
      f = '0;
      for (int m = 0; m < 16; m++) begin
         f[4*m]     = pf[m];
         f[4*m + 1] = sa[m];
         f[4*m + 2] = sb[m];
      end
      return f;
   endfunction

   // ------------------------------------------------------------
   // pins one cycle behind the frame and zero with the interlock open
   // ------------------------------------------------------------
   pins_follow_frame: assert property (@(posedge gbt_data_x) disable iff (!rst_n_i)
      $past(rst_n_i) |-> {boost_i, dir_i, en_i, clk_i} ==
         ($past(motor_enable_i) ? {lane_bits($past(frame_rx_i), 3),
                                   lane_bits($past(frame_rx_i), 2),
                                   lane_bits($past(frame_rx_i), 1),
                                   lane_bits($past(frame_rx_i), 0)} : 64'd0))
      else begin
         $error("motor pins differ from the frame received one cycle before");
         fail_count++;
      end

   // ------------------------------------------------------------
   // sent frame carries the status or a loopback copy
   // ------------------------------------------------------------
   status_in_frame: assert property (@(posedge gbt_data_x) disable iff (!rst_n_i)
      ($past(rst_n_i) && !$past(frame_loop_i)) |->
         frame_tx_i == status_frame($past(pfail_i), $past(sw_a_i), $past(sw_b_i)))
      else begin
         $error("sent frame does not carry the status pins of the cycle before");
         fail_count++;
      end

   loop_copies_frame: assert property (@(posedge gbt_data_x) disable iff (!rst_n_i)
      ($past(rst_n_i) && $past(frame_loop_i)) |-> frame_tx_i == $past(frame_rx_i))
      else begin
         $error("looped frame is not the frame received one cycle before");
         fail_count++;
      end

endmodule

`default_nettype wire

/* tb/tb_mcoi_frame_system.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mcoi_frame_system;

   localparam logic [30:0]        BUILD_NUMBER   = 31'h0123_4567;
   localparam mcoi_pkg::sc_word_t INTERLOCK_KEY  = 32'h6e0f_1c3a;
   // about twice the length of all tests
   localparam int                 TIMEOUT_CYCLES = 6000;
   // worst reply latency is about 8 cycles
   localparam int                 REPLY_WAIT     = 64;

   logic                   gbt_data_x;
   logic                   rst_n_i;
   mcoi_pkg::motor_frame_t frame_rx;
   mcoi_pkg::motor_frame_t frame_tx;
   logic [1:0]             sc_rx;
   logic [1:0]             sc_tx;
   mcoi_pkg::motor_pins_t  pfail;
   mcoi_pkg::motor_pins_t  sw_a;
   mcoi_pkg::motor_pins_t  sw_b;
   mcoi_pkg::motor_pins_t  boost;
   mcoi_pkg::motor_pins_t  dir;
   mcoi_pkg::motor_pins_t  en;
   mcoi_pkg::motor_pins_t  clk;

   integer             seed;
   int                 errors = 0;
   int                 cycles = 0;
   // lane 1 history, for the count and enable pages
   int                 lane1_words = 0;
   mcoi_pkg::sc_word_t lane1_last = '0;

   mcoi_frame_system #(
      .BUILD_NUMBER  (BUILD_NUMBER),
      .INTERLOCK_KEY (INTERLOCK_KEY)
   ) dut (
      .gbt_data_x    (gbt_data_x),
      .rst_n_i       (rst_n_i),
      .frame_rx_i    (frame_rx),
      .frame_tx_o    (frame_tx),
      .sc_rx_i       (sc_rx),
      .sc_tx_o       (sc_tx),
      .motor_pfail_i (pfail),
      .motor_sw_a_i  (sw_a),
      .motor_sw_b_i  (sw_b),
      .motor_boost_o (boost),
      .motor_dir_o   (dir),
      .motor_en_o    (en),
      .motor_clk_o   (clk)
   );

   bind mcoi_frame_system mcoi_frame_system_properties i_frame_props (
      .gbt_data_x     (gbt_data_x),
      .rst_n_i        (rst_n_i),
      .frame_rx_i     (frame_rx_i),
      .frame_tx_i     (frame_tx_o),
      .pfail_i        (motor_pfail_i),
      .sw_a_i         (motor_sw_a_i),
      .sw_b_i         (motor_sw_b_i),
      .boost_i        (motor_boost_o),
      .dir_i          (motor_dir_o),
      .en_i           (motor_en_o),
      .clk_i          (motor_clk_o),
      .motor_enable_i (motor_enable),
      .frame_loop_i   (frame_loop)
   );

   initial gbt_data_x = 1'b0;
   always #50 gbt_data_x = ~gbt_data_x;

   // run limit
   always @(posedge gbt_data_x) begin
      cycles = cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("timeout: tests still running after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // ------------------------------------------------------------
   // lane serializer and reply capture
   // ------------------------------------------------------------

   // start bit, 32 bits msb first, stop bit
   task automatic send_word(input int lane, input mcoi_pkg::sc_word_t word);
      logic [33:0] bits;
      bits = {1'b0, word, 1'b1};
      for (int i = 33; i >= 0; i--) begin
         @(posedge gbt_data_x);
         #10;
         sc_rx[lane] = bits[i];
      end
   endtask

   // send one word, capture the reply from sc_tx and compare
   task automatic exchange_word(input int lane, input mcoi_pkg::sc_word_t word,
                                input mcoi_pkg::sc_word_t exp);
      mcoi_pkg::sc_word_t got;
      int                 waited;
      got    = '0;
      waited = 0;
      send_word(lane, word);
      @(posedge gbt_data_x);
      #10;
      while (sc_tx[lane] && waited < REPLY_WAIT) begin
         @(posedge gbt_data_x);
         #10;
         waited++;
      end
      if (sc_tx[lane]) begin
         $display("no reply on lane %0d within %0d cycles", lane, REPLY_WAIT);
         errors++;
      end else begin
         for (int i = 0; i < 32; i++) begin
            @(posedge gbt_data_x);
            #10;
            got = {got[30:0], sc_tx[lane]};
         end
         @(posedge gbt_data_x);
         #10;
         if (!sc_tx[lane]) begin
            $display("reply on lane %0d has no stop bit", lane);
            errors++;
         end
         check_value($sformatf("sc_tx_o[%0d]", lane), 64'(got), 64'(exp));
      end
   endtask

   // lane 1 echoes, and its history feeds the later page checks
   task automatic send_lane1(input mcoi_pkg::sc_word_t word);
      exchange_word(1, word, word);
      lane1_words++;
      lane1_last = word;
   endtask

   task automatic random_frames(input int n);
      repeat (n) begin
         @(posedge gbt_data_x);
         #10;
         frame_rx = {$random(seed), $random(seed)};
      end
   endtask

   task automatic random_status(input int n);
      logic [31:0] rnd;
      repeat (n) begin
         @(posedge gbt_data_x);
         #10;
         rnd   = $random(seed);
         pfail = rnd[15:0];
         sw_a  = rnd[31:16];
         rnd   = $random(seed);
         sw_b  = rnd[15:0];
      end
   endtask

   // ------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------
   initial begin
      seed     = 32'ha8ef;
      rst_n_i  = 1'b0;
      frame_rx = '0;
      sc_rx    = 2'b11;
      pfail    = '0;
      sw_a     = '0;
      sw_b     = '0;
      repeat (8) @(posedge gbt_data_x);
      #10;
      rst_n_i = 1'b1;
      @(posedge gbt_data_x);
      #10;

      // idle state after reset, then build number with the flag clear
      check_value("motor pins", {boost, dir, en, clk}, 64'd0);
      check_value("frame_tx_o", frame_tx, 64'd0);
      check_value("sc_tx_o", 64'(sc_tx), 64'd3);
      exchange_word(0, 32'h0000_0000, {1'b0, BUILD_NUMBER});

      // interlock closed, pins follow the frame
      send_lane1(INTERLOCK_KEY);
      random_frames(500);

      // interlock open, pins stay low
      send_lane1(32'h1234_5678);
      random_frames(500);

      // status pins into the sent frame
      random_status(500);

      // frame loopback on
      exchange_word(0, 32'h8000_0000, {1'b1, BUILD_NUMBER});
      random_frames(200);

      // shared memory seen from lane 0, which also drops the loop flag
      send_lane1(32'haabb_ccdd);
      exchange_word(0, 32'h0000_0001, 32'haabb_ccdd);
      exchange_word(0, 32'h0000_0002, lane1_words);
      exchange_word(0, 32'h0000_0003, {31'd0, lane1_last == INTERLOCK_KEY});
      send_lane1(INTERLOCK_KEY);
      exchange_word(0, 32'h0000_0003, {31'd0, lane1_last == INTERLOCK_KEY});
      exchange_word(0, 32'h0000_0002, lane1_words);
      random_frames(50);

      $display("summary: %0d check errors, %0d assertion failures, %0d cycles",
               errors, dut.i_frame_props.fail_count, cycles);
      if (errors == 0 && dut.i_frame_props.fail_count == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* mcoi_frame_system.f */
hdl/mcoi_pkg.sv
hdl/wb_if.sv
hdl/serial_register.sv
hdl/page_selector.sv
hdl/loopback_register.sv
hdl/wb_arbiter.sv
hdl/config_memory.sv
hdl/motor_frame_mux.sv
hdl/mcoi_frame_system.sv
tb/mcoi_frame_system_properties.sv
tb/tb_mcoi_frame_system.sv

/* Makefile */
# Verilator flow for the motor controller frame system
# every variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= mcoi_frame_system.f
RTL_TOP   ?= mcoi_frame_system
TB_TOP    ?= tb_mcoi_frame_system
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+100
VFLAGS    ?= --timing --assert

PASS_MSG  := Simulation passed

.PHONY: all lint sim clean

all: sim

# lint the synthesizable top level
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# build and run the testbench; the log decides pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)
	$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "log check: pass message found"; \
	else \
		echo "log check: pass message missing"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
